/* bus_decode.sv */
`timescale 1ns/100ps

module bus_decode (
    input  logic              clk,
    input  logic              rst,
    input  bus_pkg::bus_req_t req,
    input  logic              req_valid,
    output logic              req_ready,
    input  logic              slot_free,
    input  logic              ram_busy,
    output map_pkg::dec_req_t dec,
    output logic              ram_go,
    output logic              flash_go,
    output logic              gpio_go,
    output logic              none_go
);

    logic full;
    logic settled;
    logic load;
    logic dispatch;

    // an entry spends one full cycle in the stage before it may leave
    assign dispatch  = full && settled && slot_free && !ram_busy;
    assign req_ready = !full || dispatch;
    assign load      = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            full    <= 1'b0;
            settled <= 1'b0;
        end else begin
            if (load) begin
                full <= 1'b1;
            end else if (dispatch) begin
                full <= 1'b0;
            end
            settled <= full && !load;    // a fresh entry restarts its wait
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            dec.req    <= req;
            dec.region <= map_pkg::region_of(req.addr);
        end
    end

    assign ram_go   = dispatch && (dec.region == map_pkg::REG_RAM);
    assign flash_go = dispatch && (dec.region == map_pkg::REG_FLASH);
    assign gpio_go  = dispatch && (dec.region == map_pkg::REG_GPIO);
    assign none_go  = dispatch && (dec.region == map_pkg::REG_NONE);

    a_one_go: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({ram_go, flash_go, gpio_go, none_go})
    ) else $error("more than one dispatch strobe in a cycle");

endmodule

/* bus_pkg.sv */
package bus_pkg;

    localparam int DATA_W = 32;
    localparam int ADDR_W = 32;
    localparam int MASK_W = DATA_W / 8;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } bus_op_e;

    // one request word from the processor port
    typedef struct packed {
        bus_op_e             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
        logic [MASK_W-1:0]   mask;
    } bus_req_t;

    typedef struct packed {
        logic [DATA_W-1:0]   rdata;
        logic                err;    // set for unmapped access or a write to flash
    } bus_resp_t;

    // replaces the bytes of old_word selected by mask with those of new_word
    function automatic logic [DATA_W-1:0] merge_bytes(
        input logic [DATA_W-1:0] old_word,
        input logic [DATA_W-1:0] new_word,
        input logic [MASK_W-1:0] mask
    );
        logic [DATA_W-1:0] merged;
        merged = old_word;
        for (int b = 0; b < MASK_W; b++) begin
            if (mask[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return merged;
    endfunction

endpackage

/* bus_result.sv */
`timescale 1ns/100ps

module bus_result (
    input  logic               clk,
    input  logic               rst,
    input  logic               ram_done,
    input  logic               flash_done,
    input  logic               gpio_done,
    input  logic               none_go,
    input  bus_pkg::bus_resp_t ram_resp,
    input  bus_pkg::bus_resp_t flash_resp,
    input  bus_pkg::bus_resp_t gpio_resp,
    output logic               slot_free,
    output bus_pkg::bus_resp_t resp,
    output logic               resp_valid,
    input  logic               resp_ready
);

    logic               capture;
    bus_pkg::bus_resp_t next_resp;

    assign capture = ram_done || flash_done || gpio_done || none_go;

    always_comb begin
        next_resp = '{rdata: '0, err: 1'b1};    // unmapped access
        if (ram_done) begin
            next_resp = ram_resp;
        end else if (flash_done) begin
            next_resp = flash_resp;
        end else if (gpio_done) begin
            next_resp = gpio_resp;
        end
    end

    assign slot_free = !resp_valid || resp_ready;    // empty, or emptying on this edge

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (capture) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            resp <= next_resp;
        end
    end

    a_hold: assert property (
        @(posedge clk) disable iff (rst)
        (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp))
    ) else $error("response changed while stalled");

    a_one_source: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({ram_done, flash_done, gpio_done, none_go})
    ) else $error("two sources finished in one cycle");

endmodule

/* data_bus_top.sv */
`timescale 1ns/100ps

module data_bus_top (
    input  logic                       clk,
    input  logic                       rst,
    input  bus_pkg::bus_req_t          req,
    input  logic                       req_valid,
    output logic                       req_ready,
    output bus_pkg::bus_resp_t         resp,
    output logic                       resp_valid,
    input  logic                       resp_ready,
    input  logic [bus_pkg::DATA_W-1:0] gpio_in,
    output logic [bus_pkg::DATA_W-1:0] gpio_out
);

    map_pkg::dec_req_t  dec;
    logic               ram_go;
    logic               flash_go;
    logic               gpio_go;
    logic               none_go;
    logic               ram_busy;
    logic               slot_free;
    logic               ram_done;
    logic               flash_done;
    logic               gpio_done;
    bus_pkg::bus_resp_t ram_resp;
    bus_pkg::bus_resp_t flash_resp;
    bus_pkg::bus_resp_t gpio_resp;

    bus_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .slot_free (slot_free),
        .ram_busy  (ram_busy),
        .dec       (dec),
        .ram_go    (ram_go),
        .flash_go  (flash_go),
        .gpio_go   (gpio_go),
        .none_go   (none_go)
    );

    ram_target u_ram (
        .clk  (clk),
        .rst  (rst),
        .dec  (dec),
        .go   (ram_go),
        .busy (ram_busy),
        .done (ram_done),
        .resp (ram_resp)
    );

    flash_target u_flash (
        .clk  (clk),
        .dec  (dec),
        .go   (flash_go),
        .done (flash_done),
        .resp (flash_resp)
    );

    gpio_target u_gpio (
        .clk      (clk),
        .rst      (rst),
        .dec      (dec),
        .go       (gpio_go),
        .done     (gpio_done),
        .resp     (gpio_resp),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    bus_result u_result (
        .clk        (clk),
        .rst        (rst),
        .ram_done   (ram_done),
        .flash_done (flash_done),
        .gpio_done  (gpio_done),
        .none_go    (none_go),
        .ram_resp   (ram_resp),
        .flash_resp (flash_resp),
        .gpio_resp  (gpio_resp),
        .slot_free  (slot_free),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

endmodule

/* flash_init.hex */
// flash words 0 to 63, four 32-bit hex words per line, line n holds words 4n to 4n+3
00ffc380 01fec381 02fdc382 03fcc383
04fbc384 05fac385 06f9c386 07f8c387
08f7c388 09f6c389 0af5c38a 0bf4c38b
0cf3c38c 0df2c38d 0ef1c38e 0ff0c38f
10efc390 11eec391 12edc392 13ecc393
14ebc394 15eac395 16e9c396 17e8c397
18e7c398 19e6c399 1ae5c39a 1be4c39b
1ce3c39c 1de2c39d 1ee1c39e 1fe0c39f
20dfc3a0 21dec3a1 22ddc3a2 23dcc3a3
24dbc3a4 25dac3a5 26d9c3a6 27d8c3a7
28d7c3a8 29d6c3a9 2ad5c3aa 2bd4c3ab
2cd3c3ac 2dd2c3ad 2ed1c3ae 2fd0c3af
30cfc3b0 31cec3b1 32cdc3b2 33ccc3b3
34cbc3b4 35cac3b5 36c9c3b6 37c8c3b7
38c7c3b8 39c6c3b9 3ac5c3ba 3bc4c3bb
3cc3c3bc 3dc2c3bd 3ec1c3be 3fc0c3bf

/* flash_target.sv */
`timescale 1ns/100ps

module flash_target (
    input  logic               clk,
    input  map_pkg::dec_req_t  dec,
    input  logic               go,
    output logic               done,
    output bus_pkg::bus_resp_t resp
);

    logic [bus_pkg::DATA_W-1:0]       rom [0:(1 << map_pkg::FLASH_ADDR_W)-1];
    logic [map_pkg::FLASH_ADDR_W-1:0] word_addr;
    logic                             is_write;

    initial begin
        $readmemh("flash_init.hex", rom);
    end

    assign word_addr = dec.req.addr[2 +: map_pkg::FLASH_ADDR_W];
    assign is_write  = (dec.req.op == bus_pkg::OP_WRITE);

    assign done = go;    // answers in the dispatch cycle

    // writes are refused and never touch the array
    assign resp.rdata = is_write ? '0 : rom[word_addr];
    assign resp.err   = is_write;

    a_region: assert property (
        @(posedge clk)
        go |-> (dec.region == map_pkg::REG_FLASH)
    ) else $error("flash dispatched for another region");

endmodule

/* flist.f */
+incdir+.
bus_pkg.sv
map_pkg.sv
bus_decode.sv
ram_target.sv
flash_target.sv
gpio_target.sv
bus_result.sv
data_bus_top.sv
tb_data_bus.sv

/* gpio_target.sv */
`timescale 1ns/100ps

module gpio_target (
    input  logic                       clk,
    input  logic                       rst,
    input  map_pkg::dec_req_t          dec,
    input  logic                       go,
    output logic                       done,
    output bus_pkg::bus_resp_t         resp,
    input  logic [bus_pkg::DATA_W-1:0] gpio_in,
    output logic [bus_pkg::DATA_W-1:0] gpio_out
);

    logic [map_pkg::GPIO_ADDR_W-1:0] word_addr;
    logic                            is_write;
    logic                            out_sel;
    logic [bus_pkg::DATA_W-1:0]      out_q;
    logic [bus_pkg::DATA_W-1:0]      in_s1;
    logic [bus_pkg::DATA_W-1:0]      in_s2;

    assign word_addr = dec.req.addr[2 +: map_pkg::GPIO_ADDR_W];
    assign is_write  = (dec.req.op == bus_pkg::OP_WRITE);
    assign out_sel   = (word_addr == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_q <= '0;
        end else if (go && is_write && out_sel) begin
            out_q <= bus_pkg::merge_bytes(out_q, dec.req.wdata, dec.req.mask);
        end
    end

    // pins are asynchronous to the bus
    always_ff @(posedge clk) begin
        in_s1 <= gpio_in;
        in_s2 <= in_s1;
    end

    assign gpio_out = out_q;
    assign done     = go;

    // a write to the input word is dropped quietly
    assign resp.rdata = is_write ? '0 : (out_sel ? out_q : in_s2);
    assign resp.err   = 1'b0;

endmodule

/* map_pkg.sv */
package map_pkg;

    typedef enum logic [1:0] {
        REG_RAM,
        REG_FLASH,
        REG_GPIO,
        REG_NONE
    } region_e;

    localparam int PREFIX_W = 4;    // top nibble of the byte address picks the region

    localparam logic [PREFIX_W-1:0] RAM_PREFIX   = 4'h0;
    localparam logic [PREFIX_W-1:0] FLASH_PREFIX = 4'h1;
    localparam logic [PREFIX_W-1:0] GPIO_PREFIX  = 4'hB;

    localparam int RAM_ADDR_W   = 8;
    localparam int FLASH_ADDR_W = 6;
    localparam int GPIO_ADDR_W  = 1;    // word 0 drives the pins, word 1 samples them

    localparam int RAM_WAIT = 3;
    typedef logic [$clog2(RAM_WAIT + 1)-1:0] ram_cnt_t;

    typedef struct packed {
        bus_pkg::bus_req_t req;
        region_e           region;
    } dec_req_t;

    function automatic region_e region_of(input logic [bus_pkg::ADDR_W-1:0] addr);
        region_e region;
        case (addr[bus_pkg::ADDR_W-1 -: PREFIX_W])
            RAM_PREFIX:   region = REG_RAM;
            FLASH_PREFIX: region = REG_FLASH;
            GPIO_PREFIX:  region = REG_GPIO;
            default:      region = REG_NONE;
        endcase
        return region;
    endfunction

endpackage

/* ram_target.sv */
`timescale 1ns/100ps

module ram_target (
    input  logic               clk,
    input  logic               rst,
    input  map_pkg::dec_req_t  dec,
    input  logic               go,
    output logic               busy,
    output logic               done,
    output bus_pkg::bus_resp_t resp
);

    logic [bus_pkg::DATA_W-1:0]     mem [0:(1 << map_pkg::RAM_ADDR_W)-1];
    logic [map_pkg::RAM_ADDR_W-1:0] word_addr;
    logic                           is_write;
    logic [bus_pkg::DATA_W-1:0]     rdata_q;
    map_pkg::ram_cnt_t              cnt;

    assign word_addr = dec.req.addr[2 +: map_pkg::RAM_ADDR_W];
    assign is_write  = (dec.req.op == bus_pkg::OP_WRITE);

    always_ff @(posedge clk) begin
        if (go && is_write) begin
            mem[word_addr] <= bus_pkg::merge_bytes(mem[word_addr], dec.req.wdata,
                                                   dec.req.mask);
        end
    end

    // read data is taken at dispatch and held through the wait
    always_ff @(posedge clk) begin
        if (go) begin
            rdata_q <= is_write ? '0 : mem[word_addr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (go) begin
            cnt <= map_pkg::ram_cnt_t'(map_pkg::RAM_WAIT);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    assign busy = (cnt != '0);    // covers the done cycle so nothing else lands in result
    assign done = (cnt == map_pkg::ram_cnt_t'(1));

    assign resp.rdata = rdata_q;
    assign resp.err   = 1'b0;

    a_no_overlap: assert property (
        @(posedge clk) disable iff (rst)
        go |-> !busy
    ) else $error("RAM dispatched while busy");

endmodule

/* tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [bus_pkg::DATA_W-1:0] ram_model [0:(1 << map_pkg::RAM_ADDR_W)-1];
logic [bus_pkg::DATA_W-1:0] flash_model [0:(1 << map_pkg::FLASH_ADDR_W)-1];
logic [bus_pkg::DATA_W-1:0] gpio_model = '0;
bus_pkg::bus_resp_t         exp_q[$];
int                         lat_q[$];    // cycles from request handshake to resp_valid

initial begin
    $readmemh("flash_init.hex", flash_model);
end

function automatic logic [bus_pkg::DATA_W-1:0] apply_mask(
    input logic [bus_pkg::DATA_W-1:0] cur,
    input logic [bus_pkg::DATA_W-1:0] wdata,
    input logic [bus_pkg::MASK_W-1:0] mask
);
    logic [bus_pkg::DATA_W-1:0] bits;
    for (int i = 0; i < bus_pkg::MASK_W; i++)
        bits[8*i +: 8] = {8{mask[i]}};
    return (cur & ~bits) | (wdata & bits);
endfunction

// updates the mirrored state and queues the response the bus owes for r
task automatic model_accept(
    input bus_pkg::bus_req_t          r,
    input logic [bus_pkg::DATA_W-1:0] pins
);
    bus_pkg::bus_resp_t              e;
    logic [map_pkg::RAM_ADDR_W-1:0]  ra;
    logic [map_pkg::GPIO_ADDR_W-1:0] ga;
    logic                            wr;
    int                              lat;
    e = '{rdata: '0, err: 1'b0};
    ra = r.addr[2 +: map_pkg::RAM_ADDR_W];
    ga = r.addr[2 +: map_pkg::GPIO_ADDR_W];
    wr = (r.op == bus_pkg::OP_WRITE);
    lat = 2;
    case (r.addr[bus_pkg::ADDR_W-1 -: map_pkg::PREFIX_W])
        map_pkg::RAM_PREFIX: begin
            lat = 2 + map_pkg::RAM_WAIT;
            if (wr)
                ram_model[ra] = apply_mask(ram_model[ra], r.wdata, r.mask);
            else
                e.rdata = ram_model[ra];
        end
        map_pkg::FLASH_PREFIX: begin
            e.err = wr;    // flash is read-only
            if (!wr)
                e.rdata = flash_model[r.addr[2 +: map_pkg::FLASH_ADDR_W]];
        end
        map_pkg::GPIO_PREFIX: begin
            if (wr && ga == '0)
                gpio_model = apply_mask(gpio_model, r.wdata, r.mask);
            else if (!wr)
                e.rdata = (ga == '0) ? gpio_model : pins;
        end
        default: e.err = 1'b1;
    endcase
    exp_q.push_back(e);
    lat_q.push_back(lat);
endtask

`endif

/* tb_data_bus.sv */
`timescale 1ns/100ps

module tb_data_bus;

    localparam int N_RAM_INIT  = 1 << map_pkg::RAM_ADDR_W;
    localparam int N_RAM_MIX   = 96;
    localparam int N_FLASH_RD  = 32;
    localparam int N_FLASH_WR  = 8;
    localparam int GPIO_ROUNDS = 4;
    localparam int N_UNMAPPED  = 24;
    localparam int N_MIXED     = 200;
    localparam int N_LATENCY   = 40;
    localparam int TOTAL_REQ   = N_RAM_INIT + N_RAM_MIX + N_FLASH_RD + 2 * N_FLASH_WR
                                 + 7 * GPIO_ROUNDS + 2 * N_UNMAPPED + N_MIXED + N_LATENCY;
    localparam int CYCLE_LIMIT = 4 * TOTAL_REQ * (2 + map_pkg::RAM_WAIT) + 200;

    logic                       clk = 1'b0;
    logic                       rst;
    bus_pkg::bus_req_t          req;
    logic                       req_valid;
    logic                       req_ready;
    bus_pkg::bus_resp_t         resp;
    logic                       resp_valid;
    logic                       resp_ready;
    logic [bus_pkg::DATA_W-1:0] gpio_in;
    logic [bus_pkg::DATA_W-1:0] gpio_out;
    bus_pkg::bus_req_t          stim_q[$];
    int                         errors = 0;
    int                         tests_passed = 0;
    int                         tests_failed = 0;
    int                         cycles = 0;

    `include "tb_model.svh"

    data_bus_top u_dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: responses stalled, run stopped after %0d cycles", cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_resp(input string name, input bus_pkg::bus_resp_t exp,
                              input bus_pkg::bus_resp_t act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %s expected rdata=%h err=%h, actual rdata=%h err=%h",
                     name, exp.rdata, exp.err, act.rdata, act.err);
        end
    endtask

    task automatic check_gpio(input logic [bus_pkg::DATA_W-1:0] exp,
                              input logic [bus_pkg::DATA_W-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] gpio_out expected %h, actual %h", exp, act);
        end
    endtask

    task automatic check_latency(input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("[FAIL] resp_valid latency expected %h, actual %h cycles", exp, act);
        end
    endtask

    task automatic report_problem(input string msg);
        errors++;
        $display("error: %s", msg);
    endtask

    task automatic report_test(input string name, input int first);
        if (errors == first) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - first);
        end
    endtask

    // kind 0 RAM, 1 flash, 2 GPIO, anything else an unmapped prefix
    function automatic bus_pkg::bus_req_t rand_req(input int kind);
        bus_pkg::bus_req_t             r;
        logic [map_pkg::PREFIX_W-1:0]  prefix;
        r.addr = $urandom();
        r.wdata = $urandom();
        r.mask = bus_pkg::MASK_W'($urandom_range(15));
        r.op = ($urandom_range(1) == 1) ? bus_pkg::OP_WRITE : bus_pkg::OP_READ;
        case (kind)
            0: prefix = map_pkg::RAM_PREFIX;
            1: prefix = map_pkg::FLASH_PREFIX;
            2: prefix = map_pkg::GPIO_PREFIX;
            default: begin
                do
                    prefix = map_pkg::PREFIX_W'($urandom_range(15));
                while (prefix == map_pkg::RAM_PREFIX || prefix == map_pkg::FLASH_PREFIX
                       || prefix == map_pkg::GPIO_PREFIX);
            end
        endcase
        r.addr[bus_pkg::ADDR_W-1 -: map_pkg::PREFIX_W] = prefix;
        return r;
    endfunction

    // sends stim_q, checks every response, serial sends one request at a time
    task automatic run_stream(input int stall_pct, input logic serial);
        int                 total;
        int                 got;
        int                 edge_no;
        int                 hs_edge;
        logic               in_flight;
        logic               accepted;
        logic               hold_prev;
        bus_pkg::bus_resp_t held;
        total = stim_q.size();
        got = 0;
        edge_no = 0;
        hs_edge = 0;
        in_flight = 1'b0;
        hold_prev = 1'b0;
        while (got < total) begin
            @(posedge clk);
            edge_no++;
            if (hold_prev) begin
                if (!resp_valid)
                    report_problem("resp_valid dropped while the response was stalled");
                check_resp("resp (held)", held, resp);
            end
            if (resp_valid && resp_ready) begin
                got++;
                in_flight = 1'b0;
                if (exp_q.size() == 0) begin
                    report_problem("a response arrived with no request outstanding");
                end else begin
                    check_resp("resp", exp_q.pop_front(), resp);
                    if (serial) begin
                        // resp_valid rose on the edge before this handshake
                        check_latency(lat_q.pop_front(), edge_no - hs_edge - 1);
                        check_gpio(gpio_model, gpio_out);
                    end else begin
                        void'(lat_q.pop_front());
                    end
                end
            end
            hold_prev = resp_valid && !resp_ready;
            held = resp;
            accepted = req_valid && req_ready;
            if (accepted) begin
                model_accept(stim_q.pop_front(), gpio_in);
                hs_edge = edge_no;
                in_flight = 1'b1;
            end
            #1;
            if (!req_valid || accepted)    // an offered request stays until it is taken
                req_valid = (stim_q.size() > 0)
                            && (serial ? !in_flight : ($urandom_range(3) != 0));
            if (stim_q.size() > 0)
                req = stim_q[0];
            resp_ready = ($urandom_range(99) >= stall_pct);
        end
        req_valid = 1'b0;
        resp_ready = 1'b1;
        repeat (8) begin
            @(posedge clk);
            if (resp_valid)
                report_problem("an extra response arrived after all requests were answered");
        end
        #1;
        check_gpio(gpio_model, gpio_out);
    endtask

    initial begin
        bus_pkg::bus_req_t r;
        int                first;
        void'($urandom(66));
        rst = 1'b1;
        req = '0;
        req_valid = 1'b0;
        resp_ready = 1'b0;
        gpio_in = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_gpio(gpio_model, gpio_out);

        first = errors;
        for (int i = 0; i < N_RAM_INIT; i++) begin
            r = rand_req(0);
            r.op = bus_pkg::OP_WRITE;
            r.mask = '1;
            r.addr[2 +: map_pkg::RAM_ADDR_W] = i[map_pkg::RAM_ADDR_W-1:0];
            stim_q.push_back(r);
        end
        for (int i = 0; i < N_RAM_MIX; i++)
            stim_q.push_back(rand_req(0));
        run_stream(0, 1'b0);
        report_test("1 ram write/read", first);

        first = errors;
        for (int i = 0; i < N_FLASH_RD + N_FLASH_WR; i++) begin
            r = rand_req(1);
            r.op = (i < N_FLASH_RD) ? bus_pkg::OP_READ : bus_pkg::OP_WRITE;
            stim_q.push_back(r);
            r.op = bus_pkg::OP_READ;    // the refused word is read back
            if (i >= N_FLASH_RD)
                stim_q.push_back(r);
        end
        run_stream(0, 1'b0);
        report_test("2 flash read/refused write", first);

        first = errors;
        for (int k = 0; k < GPIO_ROUNDS; k++) begin
            gpio_in = $urandom();
            repeat (4) @(posedge clk);    // longer than the two-flop synchronizer
            #1;
            for (int i = 0; i < 7; i++) begin
                r = rand_req(2);
                r.op = (i < 4 || i == 6) ? bus_pkg::OP_WRITE : bus_pkg::OP_READ;
                r.addr[2] = (i >= 5);
                stim_q.push_back(r);
            end
            run_stream(0, 1'b1);
        end
        report_test("3 gpio", first);

        first = errors;
        for (int i = 0; i < 2 * N_UNMAPPED; i++)
            stim_q.push_back(rand_req((i % 2 == 0) ? 3 : $urandom_range(2)));
        run_stream(0, 1'b0);
        report_test("4 unmapped", first);

        first = errors;
        for (int i = 0; i < N_MIXED; i++)
            stim_q.push_back(rand_req($urandom_range(3)));
        run_stream(40, 1'b0);
        report_test("5 back-pressure and ordering", first);

        first = errors;
        for (int i = 0; i < N_LATENCY; i++)
            stim_q.push_back(rand_req($urandom_range(3)));
        run_stream(0, 1'b1);
        report_test("6 latency", first);

        $display("summary: %0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
